// File: Bender.yml
package:
  name: nn_engine

sources:
  - hw/nn_pkg.sv
  - hw/nn_weight_mem.sv
  - hw/nn_sequencer.sv
  - hw/nn_mac_stage.sv
  - hw/nn_score_argmax.sv
  - hw/nn_top.sv
  - target: test
    files:
      - verification/nn_tb.sv

// File: hw/nn_mac_stage.sv
// one MAC, no stall, products kept at 64 bits, rescale truncates toward minus infinity and wraps
`timescale 1ns/1ps

module nn_mac_stage (
  input  logic                clk,
  input  logic                rst,
  input  nn_pkg::mac_op_t     op,
  input  nn_pkg::word_t       input_rd,
  input  nn_pkg::word_t       hidden_rd,
  input  nn_pkg::word_t       w_ih_rd,
  input  nn_pkg::word_t       w_ho_rd,
  output nn_pkg::mem_wr_t     hidden_wr,
  output nn_pkg::neuron_res_t score_res
);
  import nn_pkg::*;

  mac_op_t op_d;      // lines up with memory read data
  mac_op_t op_p;      // lines up with prod_q
  word_t   act;
  word_t   wgt;
  acc_t    prod_q;
  acc_t    acc_q;
  acc_t    acc_nxt;
  acc_t    scaled;
  word_t   res_val;   // rescaled, wrapped to 32 bits
  word_t   relu_val;
  logic    res_last;

  // ==================================================
  // operand select and datapath
  // ==================================================
  always_comb begin
    act      = (op_d.layer == LAYER_HIDDEN) ? input_rd : hidden_rd;
    wgt      = (op_d.layer == LAYER_HIDDEN) ? w_ih_rd : w_ho_rd;
    acc_nxt  = op_p.first ? prod_q : acc_q + prod_q;  // restart per neuron
    scaled   = acc_nxt >>> frac_bits;                 // arithmetic shift
    res_val  = scaled[word_w-1:0];                    // no saturation
    relu_val = res_val[word_w-1] ? '0 : res_val;
    res_last = op_p.valid && op_p.last;
  end

  // op delay line
  always_ff @(posedge clk) begin
    if (rst) begin
      op_d <= '0;
      op_p <= '0;
    end else begin
      op_d <= op;
      op_p <= op_d;
    end
  end

  always_ff @(posedge clk) begin
    prod_q <= acc_t'(act) * acc_t'(wgt);  // sign extended operands
    if (op_p.valid) begin
      acc_q <= acc_nxt;
    end
  end

  // result registers, mac_depth after the last op
  always_ff @(posedge clk) begin
    hidden_wr.addr  <= addr_w'(op_p.neuron);
    hidden_wr.data  <= relu_val;
    score_res.index <= op_p.neuron;
    score_res.value <= res_val;   // output layer has no activation
    if (rst) begin
      hidden_wr.we    <= 1'b0;
      score_res.valid <= 1'b0;
    end else begin
      hidden_wr.we    <= res_last && (op_p.layer == LAYER_HIDDEN);
      score_res.valid <= res_last && (op_p.layer == LAYER_OUTPUT);
    end
  end

  // a neuron opened by first is closed by last before the next first
  a_first_last: assert property (@(posedge clk) disable iff (rst)
    (op.valid && op.first) |=> (!(op.valid && op.first) until_with (op.valid && op.last)));

endmodule

// File: hw/nn_pkg.sv
// fixed 784-128-10 shape, Q16.16 values wrap on overflow, no biases, addresses sized for 17 bits
package nn_pkg;

  // ==================================================
  // network shape and number format
  // ==================================================
  localparam int n_input   = 784;
  localparam int n_hidden  = 128;
  localparam int n_output  = 10;
  localparam int word_w    = 32;     // Q16.16
  localparam int frac_bits = 16;
  localparam int acc_w     = 64;     // full product width, no guard bits
  localparam int mac_depth = 3;      // op issue to result register

  // memory depths and address widths
  localparam int w_ih_depth = n_input * n_hidden;   // 100352 words
  localparam int w_ho_depth = n_hidden * n_output;  // 1280 words
  localparam int addr_w     = $clog2(w_ih_depth);   // widest memory sets the bus
  localparam int input_aw   = $clog2(n_input);
  localparam int hidden_aw  = $clog2(n_hidden);     // also neuron index width
  localparam int w_ho_aw    = $clog2(w_ho_depth);
  localparam int score_aw   = $clog2(n_output);
  localparam int drain_w    = $clog2(mac_depth);

  typedef logic signed [word_w-1:0] word_t;
  typedef logic signed [acc_w-1:0]  acc_t;

  // ==================================================
  // enums
  // ==================================================
  typedef enum logic {LAYER_HIDDEN, LAYER_OUTPUT} layer_e;

  typedef enum logic [2:0] {
    PH_IDLE, PH_HIDDEN, PH_DRAIN, PH_OUTPUT, PH_WAIT, PH_ACK
  } phase_e;

  typedef enum logic [1:0] {MEM_INPUT, MEM_W_IH, MEM_W_HO} mem_sel_e;

  // ==================================================
  // structs
  // ==================================================
  typedef struct packed {
    logic              valid;
    mem_sel_e          sel;     // target memory
    logic [addr_w-1:0] addr;
    word_t             data;
  } load_req_t;

  typedef struct packed {
    logic              we;
    logic [addr_w-1:0] addr;    // upper bits zero for small memories
    word_t             data;
  } mem_wr_t;

  typedef struct packed {
    logic                 valid;
    logic                 first;   // restart accumulation
    logic                 last;    // final product of this neuron
    layer_e               layer;
    logic [hidden_aw-1:0] neuron;
  } mac_op_t;

  typedef struct packed {
    logic                 valid;
    logic [hidden_aw-1:0] index;
    word_t                value;
  } neuron_res_t;

endpackage

// File: hw/nn_score_argmax.sv
// scores must arrive in index order starting at 0, ties go to the lower index, readback is combinational
`timescale 1ns/1ps

module nn_score_argmax (
  input  logic                        clk,
  input  logic                        rst,
  input  nn_pkg::neuron_res_t         score_res,
  input  logic [nn_pkg::score_aw-1:0] score_addr,
  output nn_pkg::word_t               score,
  output logic [nn_pkg::score_aw-1:0] class_idx,
  output logic                        results_ready
);
  import nn_pkg::*;

  word_t               scores [n_output];
  word_t               best_q;      // running maximum
  logic [score_aw-1:0] res_idx;
  logic                is_first;
  logic                is_final;
  logic                beats;

  always_comb begin
    res_idx  = score_res.index[score_aw-1:0];
    is_first = (score_res.index == '0);
    is_final = (score_res.index == hidden_aw'(n_output - 1));
    beats    = is_first || (score_res.value > best_q);  // strict, signed
  end

  // ==================================================
  // score store
  // ==================================================
  always_ff @(posedge clk) begin
    if (score_res.valid) begin
      scores[res_idx] <= score_res.value;
    end
  end

  // argmax and done pulse
  always_ff @(posedge clk) begin
    if (rst) begin
      best_q        <= '0;
      class_idx     <= '0;
      results_ready <= 1'b0;
    end else begin
      results_ready <= score_res.valid && is_final;  // one cycle
      if (score_res.valid && beats) begin
        best_q    <= score_res.value;
        class_idx <= res_idx;
      end
    end
  end

  // host readback, unused addresses read zero
  always_comb begin
    score = '0;
    if (score_addr < score_aw'(n_output)) begin
      score = scores[score_addr];
    end
  end

endmodule

// File: hw/nn_sequencer.sv
// loads accepted only while idle, one op per cycle with no stall, run starts on a req rising edge
`timescale 1ns/1ps

module nn_sequencer (
  input  logic                        clk,
  input  logic                        rst,
  input  nn_pkg::load_req_t           load,
  input  logic                        req,
  output logic                        ack,
  output nn_pkg::mem_wr_t             input_wr,
  output nn_pkg::mem_wr_t             w_ih_wr,
  output nn_pkg::mem_wr_t             w_ho_wr,
  output logic [nn_pkg::input_aw-1:0] act_ra,
  output logic [nn_pkg::addr_w-1:0]   w_ih_ra,
  output logic [nn_pkg::w_ho_aw-1:0]  w_ho_ra,
  output nn_pkg::mac_op_t             op,
  input  logic                        results_ready
);
  import nn_pkg::*;

  phase_e               phase;
  logic                 req_q;      // for rising edge
  logic [hidden_aw-1:0] neuron;     // current neuron of the layer
  logic [input_aw-1:0]  in_idx;     // fan-in position
  logic [drain_w-1:0]   drain_cnt;
  logic                 row_end;    // last input of this neuron
  logic                 layer_end;  // last neuron of this layer

  always_comb begin
    if (phase == PH_HIDDEN) begin
      row_end   = (in_idx == input_aw'(n_input - 1));
      layer_end = (neuron == hidden_aw'(n_hidden - 1));
    end else begin
      row_end   = (in_idx == input_aw'(n_hidden - 1));
      layer_end = (neuron == hidden_aw'(n_output - 1));
    end
  end

  // ==================================================
  // run control FSM
  // ==================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      phase     <= PH_IDLE;
      req_q     <= 1'b0;
      neuron    <= '0;
      in_idx    <= '0;
      drain_cnt <= '0;
    end else begin
      req_q <= req;
      case (phase)
        PH_IDLE: if (req && !req_q) phase <= PH_HIDDEN;  // ack is low here
        PH_HIDDEN, PH_OUTPUT: begin
          if (row_end) begin
            in_idx <= '0;
            if (layer_end) begin
              neuron <= '0;
              phase  <= (phase == PH_HIDDEN) ? PH_DRAIN : PH_WAIT;
            end else begin
              neuron <= neuron + 1'b1;
            end
          end else begin
            in_idx <= in_idx + 1'b1;
          end
        end
        PH_DRAIN: begin  // let the last hidden write land
          drain_cnt <= drain_cnt + 1'b1;
          if (drain_cnt == drain_w'(mac_depth - 1)) begin
            drain_cnt <= '0;
            phase     <= PH_OUTPUT;
          end
        end
        PH_WAIT: if (results_ready) phase <= PH_ACK;
        PH_ACK:  if (!req) phase <= PH_IDLE;         // host may hold req
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // addresses and op, same cycle, both from the counters
  always_comb begin
    ack     = (phase == PH_ACK);
    act_ra  = in_idx;                                   // input or hidden buffer
    w_ih_ra = addr_w'(neuron) * addr_w'(n_input) + addr_w'(in_idx);  // neuron*fan_in + i
    w_ho_ra = '0;                                       // out of range in hidden phase
    if (phase == PH_OUTPUT) begin
      w_ho_ra = w_ho_aw'(neuron) * w_ho_aw'(n_hidden) + w_ho_aw'(in_idx);
    end
    op.valid  = (phase == PH_HIDDEN) || (phase == PH_OUTPUT);
    op.first  = (in_idx == '0);
    op.last   = row_end;
    op.layer  = (phase == PH_OUTPUT) ? LAYER_OUTPUT : LAYER_HIDDEN;
    op.neuron = neuron;
  end

  // host load decode, one cycle late
  always_ff @(posedge clk) begin
    input_wr.addr <= load.addr;
    input_wr.data <= load.data;
    w_ih_wr.addr  <= load.addr;
    w_ih_wr.data  <= load.data;
    w_ho_wr.addr  <= load.addr;
    w_ho_wr.data  <= load.data;
    if (rst) begin
      input_wr.we <= 1'b0;
      w_ih_wr.we  <= 1'b0;
      w_ho_wr.we  <= 1'b0;
    end else begin
      input_wr.we <= load.valid && (load.sel == MEM_INPUT);
      w_ih_wr.we  <= load.valid && (load.sel == MEM_W_IH);
      w_ho_wr.we  <= load.valid && (load.sel == MEM_W_HO);
    end
  end

  // host must not write memories under a running network
  a_load_idle: assert property (@(posedge clk) disable iff (rst)
    load.valid |-> (phase == PH_IDLE));

  // four-phase rule, ack drops only once req has dropped
  a_ack_fall: assert property (@(posedge clk) disable iff (rst)
    $fell(ack) |-> $past(!req));

endmodule

// File: hw/nn_top.sv
// host loads all three memories before req, results hold until the next run's output layer
`timescale 1ns/1ps

module nn_top (
  input  logic                        clk,
  input  logic                        rst,
  input  nn_pkg::load_req_t           load,
  input  logic                        req,
  output logic                        ack,
  input  logic [nn_pkg::score_aw-1:0] score_addr,
  output nn_pkg::word_t               score,
  output logic [nn_pkg::score_aw-1:0] class_idx
);
  import nn_pkg::*;

  mem_wr_t              input_wr;
  mem_wr_t              w_ih_wr;
  mem_wr_t              w_ho_wr;
  mem_wr_t              hidden_wr;   // from mac stage
  logic [input_aw-1:0]  act_ra;
  logic [addr_w-1:0]    w_ih_ra;
  logic [w_ho_aw-1:0]   w_ho_ra;
  word_t                input_rd;
  word_t                hidden_rd;
  word_t                w_ih_rd;
  word_t                w_ho_rd;
  mac_op_t              op;
  neuron_res_t          score_res;
  logic                 results_ready;

  // ==================================================
  // control
  // ==================================================
  nn_sequencer u_sequencer (
    .clk           (clk),
    .rst           (rst),
    .load          (load),
    .req           (req),
    .ack           (ack),
    .input_wr      (input_wr),
    .w_ih_wr       (w_ih_wr),
    .w_ho_wr       (w_ho_wr),
    .act_ra        (act_ra),
    .w_ih_ra       (w_ih_ra),
    .w_ho_ra       (w_ho_ra),
    .op            (op),
    .results_ready (results_ready)
  );

  // ==================================================
  // memories
  // ==================================================
  nn_weight_mem #(.depth(n_input)) u_input_mem (
    .clk (clk), .wr (input_wr), .ra (act_ra), .rd (input_rd)
  );

  nn_weight_mem #(.depth(w_ih_depth)) u_w_ih_mem (
    .clk (clk), .wr (w_ih_wr), .ra (w_ih_ra), .rd (w_ih_rd)
  );

  nn_weight_mem #(.depth(w_ho_depth)) u_w_ho_mem (
    .clk (clk), .wr (w_ho_wr), .ra (w_ho_ra), .rd (w_ho_rd)
  );

  // hidden activations, read with the low bits of the fan-in counter
  nn_weight_mem #(.depth(n_hidden)) u_hidden_mem (
    .clk (clk), .wr (hidden_wr), .ra (act_ra[hidden_aw-1:0]), .rd (hidden_rd)
  );

  // ==================================================
  // datapath
  // ==================================================
  nn_mac_stage u_mac_stage (
    .clk       (clk),
    .rst       (rst),
    .op        (op),
    .input_rd  (input_rd),
    .hidden_rd (hidden_rd),
    .w_ih_rd   (w_ih_rd),
    .w_ho_rd   (w_ho_rd),
    .hidden_wr (hidden_wr),
    .score_res (score_res)
  );

  nn_score_argmax u_score_argmax (
    .clk           (clk),
    .rst           (rst),
    .score_res     (score_res),
    .score_addr    (score_addr),
    .score         (score),
    .class_idx     (class_idx),
    .results_ready (results_ready)
  );

endmodule

// File: hw/nn_weight_mem.sv
// one write and one read port on one clock, read data one cycle late, old data on a same-address hit
`timescale 1ns/1ps

module nn_weight_mem #(
  parameter int depth = 784
) (
  input  logic                     clk,
  input  nn_pkg::mem_wr_t          wr,
  input  logic [$clog2(depth)-1:0] ra,
  output nn_pkg::word_t            rd
);
  import nn_pkg::*;

  word_t mem [depth];  // no reset, contents loaded by host

  // write port uses only the low address bits
  always_ff @(posedge clk) begin
    if (wr.we) begin
      mem[wr.addr[$clog2(depth)-1:0]] <= wr.data;
    end
  end

  // registered read
  always_ff @(posedge clk) begin
    rd <= mem[ra];
  end

  // ==================================================
  // address range checks
  // ==================================================
  // host or mac stage writing past the end would alias into low words
  a_wr_range: assert property (@(posedge clk)
    wr.we |-> (wr.addr < depth));

  // sequencer address gen must stay inside this memory once out of reset
  a_rd_range: assert property (@(posedge clk)
    !$isunknown(ra) |-> (ra < depth));

endmodule

// File: project.f
hw/nn_pkg.sv
hw/nn_weight_mem.sv
hw/nn_sequencer.sv
hw/nn_mac_stage.sv
hw/nn_score_argmax.sv
hw/nn_top.sv
verification/nn_tb.sv

// File: verification/nn_tb.sv
// directed tests on the full 784-128-10 shape, each run is about 100k cycles so the suite is slow
`timescale 1ns/1ps

module nn_tb;
  import nn_pkg::*;

  localparam int    clk_period  = 4;
  localparam int    run_cycles  = n_input * n_hidden + n_hidden * n_output + 64;
  localparam int    load_cycles = n_input + w_ih_depth + w_ho_depth + 16;
  localparam int    n_runs      = 5;
  localparam longint wd_cycles  = longint'(n_runs) * (run_cycles + load_cycles) + 20000;

  logic                clk;
  logic                rst;
  load_req_t           load;
  logic                req;
  logic                ack;
  logic [score_aw-1:0] score_addr;
  word_t               score;
  logic [score_aw-1:0] class_idx;

  // host-side copies of the memories, plus model results
  word_t               in_v [n_input];
  word_t               w_ih [w_ih_depth];
  word_t               w_ho [w_ho_depth];
  word_t               hid [n_hidden];
  word_t               exp_score [n_output];
  word_t               prev_score [n_output];
  logic [score_aw-1:0] exp_idx;
  logic [31:0]         lfsr_q;
  int                  errors;
  int                  checks;
  int                  tests;

  nn_top uut (
    .clk        (clk),
    .rst        (rst),
    .load       (load),
    .req        (req),
    .ack        (ack),
    .score_addr (score_addr),
    .score      (score),
    .class_idx  (class_idx)
  );

  always #(clk_period / 2) clk = ~clk;

  // ==================================================
  // random values
  // ==================================================
  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic        fb;
    logic [31:0] r;
    int          i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic word_t rand_q();  // signed byte / 256
    logic [31:0] t;
    t = take_bits(8);
    return {{16{t[7]}}, t[7:0], 8'h00};
  endfunction

  function automatic word_t pos_q();   // strictly positive
    logic [31:0] t;
    t = take_bits(6);
    return {17'h0, t[5:0], 1'b1, 8'h00};
  endfunction

  function automatic word_t neg_q();   // always below zero
    logic [31:0] t;
    t = take_bits(7);
    return {17'h1ffff, t[6:0], 8'h00};
  endfunction

  task automatic fill_random();
    int a;
    for (a = 0; a < n_input; a++) in_v[a] = rand_q();
    for (a = 0; a < w_ih_depth; a++) w_ih[a] = rand_q();
    for (a = 0; a < w_ho_depth; a++) w_ho[a] = rand_q();
  endtask

  // ==================================================
  // reference model
  // ==================================================
  task automatic compute_model();
    acc_t  acc;
    acc_t  sh;
    word_t v;
    int    j;
    int    i;
    for (j = 0; j < n_hidden; j++) begin
      acc = '0;
      for (i = 0; i < n_input; i++) acc += acc_t'(in_v[i]) * acc_t'(w_ih[j * n_input + i]);
      sh     = acc >>> frac_bits;   // truncates toward minus infinity
      v      = sh[word_w-1:0];
      hid[j] = v[word_w-1] ? '0 : v;  // relu
    end
    for (j = 0; j < n_output; j++) begin
      acc = '0;
      for (i = 0; i < n_hidden; i++) acc += acc_t'(hid[i]) * acc_t'(w_ho[j * n_hidden + i]);
      sh           = acc >>> frac_bits;
      exp_score[j] = sh[word_w-1:0];  // no activation on outputs
    end
    exp_idx = '0;
    for (j = 1; j < n_output; j++) begin
      if (exp_score[j] > exp_score[exp_idx]) exp_idx = score_aw'(j);  // lowest wins ties
    end
  endtask

  // ==================================================
  // host bus helpers
  // ==================================================
  task automatic load_mem(input mem_sel_e sel);
    int n;
    int a;
    n = (sel == MEM_INPUT) ? n_input : (sel == MEM_W_IH) ? w_ih_depth : w_ho_depth;
    for (a = 0; a < n; a++) begin
      @(negedge clk);
      load.valid = 1'b1;
      load.sel   = sel;
      load.addr  = addr_w'(a);
      case (sel)
        MEM_INPUT: load.data = in_v[a];
        MEM_W_IH:  load.data = w_ih[a];
        default:   load.data = w_ho[a];
      endcase
    end
    @(negedge clk);
    load = '0;
  endtask

  task automatic load_all();
    load_mem(MEM_INPUT);
    load_mem(MEM_W_IH);
    load_mem(MEM_W_HO);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t expv);
    checks++;
    assert (got === expv) else begin
      errors++;
      $display("ERROR %s: got %h expected %h", name, got, expv);
    end
  endtask

  task automatic check_results();
    int k;
    for (k = 0; k < n_output; k++) begin
      @(negedge clk);
      score_addr = score_aw'(k);
      @(negedge clk);  // combinational read settled
      check_word($sformatf("score[%0d]", k), score, exp_score[k]);
    end
    check_word("class_idx", word_t'(class_idx), word_t'(exp_idx));
  endtask

  // req up, wait ack, hold, read back, then release
  task automatic run_network(input int hold);
    int n;
    @(negedge clk);
    req = 1'b1;
    n = 0;
    while (ack !== 1'b1 && n < run_cycles + 256) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (ack === 1'b1) else begin
      errors++;
      $display("no ack within %0d cycles of req", run_cycles + 256);
    end
    repeat (hold) begin
      @(negedge clk);
      checks++;
      assert (ack === 1'b1) else begin
        errors++;
        $display("ack dropped while req was still held");
      end
    end
    check_results();
    @(negedge clk);
    req = 1'b0;
    n = 0;
    while (ack !== 1'b0 && n < 3) begin
      @(negedge clk);
      n++;
    end
    checks++;
    assert (ack === 1'b0) else begin
      errors++;
      $display("ack stayed high after req was dropped");
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) $display("%-16s ok", name);
    else $display("%-16s %0d errors", name, errors - err_before);
  endtask

  // ==================================================
  // tests
  // ==================================================
  task automatic test_reset_idle();
    int e0;
    e0 = errors;
    repeat (20) begin
      @(negedge clk);
      checks++;
      assert (ack === 1'b0) else begin
        errors++;
        $display("ack is not low after reset with req low");
      end
    end
    report_test("reset_idle", e0);
  endtask

  task automatic test_random_net();
    int e0;
    e0 = errors;
    fill_random();
    load_all();
    compute_model();
    run_network(0);
    report_test("random_net", e0);
  endtask

  task automatic test_relu_clip();
    int e0;
    int a;
    e0 = errors;
    for (a = 0; a < n_input; a++) in_v[a] = pos_q();
    for (a = 0; a < w_ih_depth; a++) w_ih[a] = neg_q();
    for (a = 0; a < w_ho_depth; a++) w_ho[a] = rand_q();
    load_all();
    for (a = 0; a < n_output; a++) exp_score[a] = '0;  // every hidden value clipped
    exp_idx = '0;    // tie at zero gives index 0
    run_network(0);
    report_test("relu_clip", e0);
  endtask

  task automatic test_tie_low_index();
    int e0;
    int r;
    int i;
    e0 = errors;
    fill_random();
    for (r = 0; r < n_output; r++) begin
      for (i = 0; i < n_hidden; i++) begin
        if (r == 7) w_ho[r * n_hidden + i] = w_ho[3 * n_hidden + i];  // copy of row 3
        else if (r == 3) w_ho[r * n_hidden + i] = pos_q();
        else w_ho[r * n_hidden + i] = neg_q();
      end
    end
    load_all();
    compute_model();
    checks++;
    assert (exp_idx == score_aw'(3)) else begin
      errors++;
      $display("tie setup did not make rows 3 and 7 the largest");
    end
    run_network(0);
    report_test("tie_low_index", e0);
  endtask

  task automatic test_back_to_back();
    int e0;
    int k;
    int diff;
    e0 = errors;
    fill_random();
    load_all();
    compute_model();
    run_network(50);   // long req hold
    check_results();   // still held after ack falls
    for (k = 0; k < n_output; k++) prev_score[k] = exp_score[k];
    for (k = 0; k < n_input; k++) in_v[k] = rand_q();
    load_mem(MEM_INPUT);  // weights kept
    compute_model();
    diff = 0;
    for (k = 0; k < n_output; k++) if (exp_score[k] != prev_score[k]) diff++;
    checks++;
    assert (diff > 0) else begin
      errors++;
      $display("new inputs give the same scores, stale results cannot be told apart");
    end
    run_network(0);
    report_test("back_to_back", e0);
  endtask

  // ==================================================
  // main sequence and watchdog
  // ==================================================
  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    req        = 1'b0;
    load       = '0;
    score_addr = '0;
    lfsr_q     = 32'hf3c8_5f76;
    errors     = 0;
    checks     = 0;
    tests      = 0;
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_reset_idle();
    test_random_net();
    test_relu_clip();
    test_tie_low_index();
    test_back_to_back();
    $display("tests %0d  checks %0d  errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // all loads and runs plus margin
  initial begin
    #(wd_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
